//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_decode_execute
FILELIST = src.f
BUILD    = obj_dir
LOG      = sim.log
FAIL_MSG = Simulation FAILED

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

//--- hdl/decode_execute_top.sv
`timescale 1ns/1ps

module decode_execute_top (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              instr_valid,
	input  logic [31:0]                       instr,
	input  logic [rv_core_pkg::xlen-1:0]      pc,
	input  logic                              flush,
	output logic                              result_valid,
	output logic [rv_core_pkg::reg_addr_w-1:0] result_rd,
	output logic [rv_core_pkg::xlen-1:0]      result_data,
	output logic                              redirect_valid,
	output logic [rv_core_pkg::xlen-1:0]      redirect_pc
);

	logic [rv_core_pkg::reg_addr_w-1:0] rs1;
	logic [rv_core_pkg::reg_addr_w-1:0] rs2;
	logic [rv_core_pkg::xlen-1:0]       rd1;
	logic [rv_core_pkg::xlen-1:0]       rd2;

	ex_bus_if d_bus ();
	ex_bus_if e_bus ();

	instr_decoder i_instr_decoder (
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.rd1         (rd1),
		.rd2         (rd2),
		.rs1         (rs1),
		.rs2         (rs2),
		.d           (d_bus.source)
	);

	// the registered result doubles as the write port.
	reg_file i_reg_file (
		.clk   (clk),
		.rst_n (rst_n),
		.ra1   (rs1),
		.ra2   (rs2),
		.we    (result_valid),
		.waddr (result_rd),
		.wdata (result_data),
		.rd1   (rd1),
		.rd2   (rd2)
	);

	id_ex_reg i_id_ex_reg (
		.clk   (clk),
		.rst_n (rst_n),
		.flush (flush),
		.d     (d_bus.sink),
		.e     (e_bus.source)
	);

	execute_stage i_execute_stage (
		.clk            (clk),
		.rst_n          (rst_n),
		.e              (e_bus.sink),
		.result_valid   (result_valid),
		.result_rd      (result_rd),
		.result_data    (result_data),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

endmodule

//--- hdl/ex_bus_if.sv
`timescale 1ns/1ps

interface ex_bus_if;

	logic                              reg_write;
	logic                              branch;
	logic                              jump;
	logic                              link;      // write pc plus four to rd.
	rv_core_pkg::alu_op_e              alu_op;
	rv_core_pkg::src_a_e               src_a;
	logic                              src_b_imm;
	logic [2:0]                        funct3;
	logic [rv_core_pkg::reg_addr_w-1:0] rs1;
	logic [rv_core_pkg::reg_addr_w-1:0] rs2;
	logic [rv_core_pkg::reg_addr_w-1:0] rd;
	logic [rv_core_pkg::xlen-1:0]      rd1;
	logic [rv_core_pkg::xlen-1:0]      rd2;
	logic [rv_core_pkg::xlen-1:0]      imm;
	logic [rv_core_pkg::xlen-1:0]      pc;

	modport source (
		output reg_write, branch, jump, link, alu_op, src_a, src_b_imm, funct3,
		output rs1, rs2, rd, rd1, rd2, imm, pc
	);

	modport sink (
		input reg_write, branch, jump, link, alu_op, src_a, src_b_imm, funct3,
		input rs1, rs2, rd, rd1, rd2, imm, pc
	);

endinterface

//--- hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
	input  logic                              clk,
	input  logic                              rst_n,
	ex_bus_if.sink                            e,
	output logic                              result_valid,
	output logic [rv_core_pkg::reg_addr_w-1:0] result_rd,
	output logic [rv_core_pkg::xlen-1:0]      result_data,
	output logic                              redirect_valid,
	output logic [rv_core_pkg::xlen-1:0]      redirect_pc
);

	logic [rv_core_pkg::xlen-1:0] fwd_a, fwd_b;
	logic [rv_core_pkg::xlen-1:0] op_a, op_b;
	logic [rv_core_pkg::xlen-1:0] alu_res;
	logic [rv_core_pkg::xlen-1:0] wb_value;
	logic [rv_core_pkg::xlen-1:0] target;
	logic [4:0]                   shamt;
	logic                         taken;
	logic                         redirect;

	// the result register holds the producer one stage ahead.
	assign fwd_a = (result_valid && result_rd == e.rs1) ? result_data : e.rd1;
	assign fwd_b = (result_valid && result_rd == e.rs2) ? result_data : e.rd2;

	always_comb begin
		case (e.src_a)
			rv_core_pkg::src_a_reg: op_a = fwd_a;
			rv_core_pkg::src_a_pc:  op_a = e.pc;
			default:                op_a = '0;
		endcase
	end

	assign op_b = e.src_b_imm ? e.imm : fwd_b;
	assign shamt = op_b[4:0];

	always_comb begin
		case (e.alu_op)
			rv_core_pkg::alu_add:    alu_res = op_a + op_b;
			rv_core_pkg::alu_sub:    alu_res = op_a - op_b;
			rv_core_pkg::alu_sll:    alu_res = op_a << shamt;
			rv_core_pkg::alu_slt:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
			rv_core_pkg::alu_sltu:   alu_res = {31'b0, op_a < op_b};
			rv_core_pkg::alu_xor:    alu_res = op_a ^ op_b;
			rv_core_pkg::alu_srl:    alu_res = op_a >> shamt;
			rv_core_pkg::alu_sra:    alu_res = $unsigned($signed(op_a) >>> shamt);
			rv_core_pkg::alu_or:     alu_res = op_a | op_b;
			rv_core_pkg::alu_and:    alu_res = op_a & op_b;
			default:                 alu_res = op_b; // pass_b for lui.
		endcase
	end

	// branches compare the forwarded registers, never the immediate.
	always_comb begin
		case (e.funct3)
			rv_core_pkg::f3_beq:  taken = (fwd_a == fwd_b);
			rv_core_pkg::f3_bne:  taken = (fwd_a != fwd_b);
			rv_core_pkg::f3_blt:  taken = ($signed(fwd_a) < $signed(fwd_b));
			rv_core_pkg::f3_bge:  taken = ($signed(fwd_a) >= $signed(fwd_b));
			rv_core_pkg::f3_bltu: taken = (fwd_a < fwd_b);
			rv_core_pkg::f3_bgeu: taken = (fwd_a >= fwd_b);
			default:              taken = 1'b0;
		endcase
	end

	assign redirect = e.jump || (e.branch && taken);
	assign wb_value = e.link ? e.pc + rv_core_pkg::xlen'(4) : alu_res;

	// jal and jalr get their target from the ALU sum.
	assign target = e.branch ? e.pc + e.imm : {alu_res[rv_core_pkg::xlen-1:1], 1'b0};

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
			redirect_valid <= 1'b0;
		end else begin
			result_valid <= e.reg_write;
			redirect_valid <= redirect;
		end
	end

	always_ff @(posedge clk) begin
		if (e.reg_write) begin
			result_rd <= e.rd;
			result_data <= wb_value;
		end
		if (redirect)
			redirect_pc <= target;
	end

endmodule

//--- hdl/id_ex_reg.sv
`timescale 1ns/1ps

module id_ex_reg (
	input logic      clk,
	input logic      rst_n,
	input logic      flush,
	ex_bus_if.sink   d,
	ex_bus_if.source e
);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			e.reg_write <= 1'b0;
			e.branch <= 1'b0;
			e.jump <= 1'b0;
			e.link <= 1'b0;
			e.alu_op <= rv_core_pkg::alu_add;
			e.src_a <= rv_core_pkg::src_a_reg;
			e.src_b_imm <= 1'b0;
			e.funct3 <= '0;
			e.rs1 <= '0;
			e.rs2 <= '0;
			e.rd <= '0;
			e.rd1 <= '0;
			e.rd2 <= '0;
			e.imm <= '0;
			e.pc <= '0;
		end else if (flush) begin
			// a squashed instruction leaves an all-zero bubble behind.
			e.reg_write <= 1'b0;
			e.branch <= 1'b0;
			e.jump <= 1'b0;
			e.link <= 1'b0;
			e.alu_op <= rv_core_pkg::alu_add;
			e.src_a <= rv_core_pkg::src_a_reg;
			e.src_b_imm <= 1'b0;
			e.funct3 <= '0;
			e.rs1 <= '0;
			e.rs2 <= '0;
			e.rd <= '0;
			e.rd1 <= '0;
			e.rd2 <= '0;
			e.imm <= '0;
			e.pc <= '0;
		end else begin
			e.reg_write <= d.reg_write;
			e.branch <= d.branch;
			e.jump <= d.jump;
			e.link <= d.link;
			e.alu_op <= d.alu_op;
			e.src_a <= d.src_a;
			e.src_b_imm <= d.src_b_imm;
			e.funct3 <= d.funct3;
			e.rs1 <= d.rs1;
			e.rs2 <= d.rs2;
			e.rd <= d.rd;
			e.rd1 <= d.rd1;
			e.rd2 <= d.rd2;
			e.imm <= d.imm;
			e.pc <= d.pc;
		end
	end

endmodule

//--- hdl/instr_decoder.sv
`timescale 1ns/1ps

module instr_decoder (
	input  logic                              instr_valid,
	input  logic [31:0]                       instr,
	input  logic [rv_core_pkg::xlen-1:0]      pc,
	input  logic [rv_core_pkg::xlen-1:0]      rd1,
	input  logic [rv_core_pkg::xlen-1:0]      rd2,
	output logic [rv_core_pkg::reg_addr_w-1:0] rs1,
	output logic [rv_core_pkg::reg_addr_w-1:0] rs2,
	ex_bus_if.source                          d
);

	logic [2:0]                         funct3;
	logic [6:0]                         funct7;
	logic [rv_core_pkg::reg_addr_w-1:0] rd;
	logic                               legal;
	logic                               supported;
	logic                               writes_rd;
	logic                               is_branch;
	logic                               is_jump;
	logic                               use_imm;
	rv_core_pkg::alu_op_e               alu_sel;
	rv_core_pkg::src_a_e                src_a_sel;
	logic [rv_core_pkg::xlen-1:0]       imm_i, imm_u, imm_b, imm_j, imm_sel;

	function automatic rv_core_pkg::alu_op_e alu_from_funct(input logic [2:0] f3,
			input logic alt);
		case (f3)
			3'b000:  return alt ? rv_core_pkg::alu_sub : rv_core_pkg::alu_add;
			3'b001:  return rv_core_pkg::alu_sll;
			3'b010:  return rv_core_pkg::alu_slt;
			3'b011:  return rv_core_pkg::alu_sltu;
			3'b100:  return rv_core_pkg::alu_xor;
			3'b101:  return alt ? rv_core_pkg::alu_sra : rv_core_pkg::alu_srl;
			3'b110:  return rv_core_pkg::alu_or;
			default: return rv_core_pkg::alu_and;
		endcase
	endfunction

	assign rs1 = instr[19:15]; // register file is read for every word.
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	assign imm_i = {{20{instr[31]}}, instr[31:20]};
	assign imm_u = {instr[31:12], 12'b0};
	assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		legal = 1'b0;
		writes_rd = 1'b0;
		is_branch = 1'b0;
		is_jump = 1'b0;
		use_imm = 1'b0;
		alu_sel = rv_core_pkg::alu_add;
		src_a_sel = rv_core_pkg::src_a_reg;
		imm_sel = '0;
		case (rv_core_pkg::opcode_e'(instr[6:0]))
			rv_core_pkg::opc_op: begin
				legal = (funct7 == rv_core_pkg::f7_base) || (funct7 == rv_core_pkg::f7_alt &&
					(funct3 == rv_core_pkg::f3_add || funct3 == rv_core_pkg::f3_sr));
				writes_rd = 1'b1;
				alu_sel = alu_from_funct(funct3, funct7[5]);
			end
			rv_core_pkg::opc_op_imm: begin
				if (funct3 == rv_core_pkg::f3_sll)
					legal = (funct7 == rv_core_pkg::f7_base);
				else if (funct3 == rv_core_pkg::f3_sr)
					legal = (funct7 == rv_core_pkg::f7_base) || (funct7 == rv_core_pkg::f7_alt);
				else
					legal = 1'b1;
				writes_rd = 1'b1;
				use_imm = 1'b1;
				imm_sel = imm_i;
				// bit 30 of the immediate only means sra on a right shift.
				alu_sel = alu_from_funct(funct3, funct3 == rv_core_pkg::f3_sr && funct7[5]);
			end
			rv_core_pkg::opc_lui: begin
				legal = 1'b1;
				writes_rd = 1'b1;
				use_imm = 1'b1;
				imm_sel = imm_u;
				alu_sel = rv_core_pkg::alu_pass_b;
				src_a_sel = rv_core_pkg::src_a_zero;
			end
			rv_core_pkg::opc_auipc: begin
				legal = 1'b1;
				writes_rd = 1'b1;
				use_imm = 1'b1;
				imm_sel = imm_u;
				src_a_sel = rv_core_pkg::src_a_pc;
			end
			rv_core_pkg::opc_jal: begin
				legal = 1'b1;
				writes_rd = 1'b1;
				is_jump = 1'b1;
				use_imm = 1'b1;
				imm_sel = imm_j;
				src_a_sel = rv_core_pkg::src_a_pc; // the ALU sum is the target.
			end
			rv_core_pkg::opc_jalr: begin
				legal = (funct3 == rv_core_pkg::f3_add);
				writes_rd = 1'b1;
				is_jump = 1'b1;
				use_imm = 1'b1;
				imm_sel = imm_i;
			end
			rv_core_pkg::opc_branch: begin
				legal = (funct3 != 3'b010) && (funct3 != 3'b011);
				is_branch = 1'b1;
				imm_sel = imm_b;
			end
			default: legal = 1'b0;
		endcase
	end

	assign supported = instr_valid && legal;

	assign d.reg_write = supported && writes_rd && (rd != '0);
	assign d.branch = supported && is_branch;
	assign d.jump = supported && is_jump;
	assign d.link = supported && is_jump;
	assign d.alu_op = supported ? alu_sel : rv_core_pkg::alu_add;
	assign d.src_a = supported ? src_a_sel : rv_core_pkg::src_a_reg;
	assign d.src_b_imm = supported && use_imm;
	assign d.funct3 = supported ? funct3 : '0;
	assign d.rs1 = supported ? rs1 : '0;
	assign d.rs2 = supported ? rs2 : '0;
	assign d.rd = supported ? rd : '0;
	assign d.rd1 = supported ? rd1 : '0;
	assign d.rd2 = supported ? rd2 : '0;
	assign d.imm = supported ? imm_sel : '0;
	assign d.pc = supported ? pc : '0;

endmodule

//--- hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [rv_core_pkg::reg_addr_w-1:0] ra1,
	input  logic [rv_core_pkg::reg_addr_w-1:0] ra2,
	input  logic                              we,
	input  logic [rv_core_pkg::reg_addr_w-1:0] waddr,
	input  logic [rv_core_pkg::xlen-1:0]      wdata,
	output logic [rv_core_pkg::xlen-1:0]      rd1,
	output logic [rv_core_pkg::xlen-1:0]      rd2
);

	localparam int nregs = 2 ** rv_core_pkg::reg_addr_w;

	logic [rv_core_pkg::xlen-1:0] regs [nregs];

	// x0 reads as zero and a write in the same cycle is passed straight through.
	function automatic logic [rv_core_pkg::xlen-1:0] read_port(
			input logic [rv_core_pkg::reg_addr_w-1:0] ra);
		if (ra == '0)
			return '0;
		else if (we && ra == waddr)
			return wdata;
		else
			return regs[ra];
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < nregs; i++)
				regs[i] <= '0;
		end else if (we && waddr != '0) begin
			regs[waddr] <= wdata;
		end
	end

	always_comb begin
		rd1 = read_port(ra1);
		rd2 = read_port(ra2);
	end

endmodule

//--- hdl/rv_core_pkg.sv
package rv_core_pkg;

	localparam int xlen = 32;
	localparam int reg_addr_w = 5;

	// major opcodes of the instruction classes this slice executes.
	typedef enum logic [6:0] {
		opc_op     = 7'b0110011,
		opc_op_imm = 7'b0010011,
		opc_lui    = 7'b0110111,
		opc_auipc  = 7'b0010111,
		opc_jal    = 7'b1101111,
		opc_jalr   = 7'b1100111,
		opc_branch = 7'b1100011
	} opcode_e;

	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_sll,
		alu_slt,
		alu_sltu,
		alu_xor,
		alu_srl,
		alu_sra,
		alu_or,
		alu_and,
		alu_pass_b
	} alu_op_e;

	// src_a_reg must stay the zero encoding so that a bubble selects it.
	typedef enum logic [1:0] {
		src_a_reg,
		src_a_pc,
		src_a_zero
	} src_a_e;

	localparam logic [2:0] f3_add = 3'b000;
	localparam logic [2:0] f3_sll = 3'b001;
	localparam logic [2:0] f3_sr  = 3'b101;

	localparam logic [2:0] f3_beq  = 3'b000;
	localparam logic [2:0] f3_bne  = 3'b001;
	localparam logic [2:0] f3_blt  = 3'b100;
	localparam logic [2:0] f3_bge  = 3'b101;
	localparam logic [2:0] f3_bltu = 3'b110;
	localparam logic [2:0] f3_bgeu = 3'b111;

	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_alt  = 7'b0100000; // selects sub and sra.

endpackage

//--- src.f
hdl/rv_core_pkg.sv
hdl/ex_bus_if.sv
hdl/instr_decoder.sv
hdl/reg_file.sv
hdl/id_ex_reg.sv
hdl/execute_stage.sv
hdl/decode_execute_top.sv
tests/tb_clock.sv
tests/decode_execute_checker.sv
tests/tb_decode_execute.sv

//--- tests/decode_execute_checker.sv
`timescale 1ns/1ps

module decode_execute_checker (
	input logic        clk,
	input logic        rst_n,
	input logic        instr_valid,
	input logic        flush,
	input logic        result_valid,
	input logic [4:0]  result_rd,
	input logic        redirect_valid,
	input logic [31:0] redirect_pc
);

	rd_nonzero_a: assert property (@(posedge clk) disable iff (!rst_n)
		result_valid |-> result_rd != 5'd0)
		else $error("result_valid is high with result_rd at x0");

	redirect_aligned_a: assert property (@(posedge clk) disable iff (!rst_n)
		redirect_valid |-> redirect_pc[0] == 1'b0)
		else $error("redirect_pc has bit 0 set while redirect_valid is high");

	// a squashed instruction would surface two cycles after it was presented.
	flush_silent_a: assert property (@(posedge clk) disable iff (!rst_n)
		flush && instr_valid |-> ##2 (!result_valid && !redirect_valid))
		else $error("a flushed instruction produced an output");

endmodule

bind decode_execute_top decode_execute_checker i_decode_execute_checker (
	.clk            (clk),
	.rst_n          (rst_n),
	.instr_valid    (instr_valid),
	.flush          (flush),
	.result_valid   (result_valid),
	.result_rd      (result_rd),
	.redirect_valid (redirect_valid),
	.redirect_pc    (redirect_pc)
);

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period.
	end

	// reset is held for three rising edges and released on a falling edge.
	initial begin
		rst_n = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
	end

endmodule

//--- tests/tb_decode_execute.sv
`timescale 1ns/1ps

module tb_decode_execute;

	logic        clk;
	logic        rst_n;
	logic        instr_valid;
	logic [31:0] instr;
	logic [31:0] pc;
	logic        flush;
	logic        result_valid;
	logic [4:0]  result_rd;
	logic [31:0] result_data;
	logic        redirect_valid;
	logic [31:0] redirect_pc;

	logic [31:0] lcg_state;
	logic [31:0] arch_regs [32]; // architectural state as the model sees it.
	logic [31:0] cur_pc;
	int          cycle;
	int          errors;
	int          checks;
	int          tests_passed;
	int          tests_failed;
	logic        timed_out;

	// outputs still to come, oldest first, with the cycle they are due in.
	int          exp_due [$];
	logic        exp_res [$];
	logic [4:0]  exp_rd [$];
	logic [31:0] exp_data [$];
	logic        exp_redir [$];
	logic [31:0] exp_target [$];

	tb_clock i_tb_clock (
		.clk   (clk),
		.rst_n (rst_n)
	);

	decode_execute_top i_decode_execute_top (
		.clk            (clk),
		.rst_n          (rst_n),
		.instr_valid    (instr_valid),
		.instr          (instr),
		.pc             (pc),
		.flush          (flush),
		.result_valid   (result_valid),
		.result_rd      (result_rd),
		.result_data    (result_data),
		.redirect_valid (redirect_valid),
		.redirect_pc    (redirect_pc)
	);

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state ^ (lcg_state >> 16); // the low lcg bits repeat quickly.
	endfunction

	// x0 to x4 only, so producers and consumers collide often.
	function automatic logic [4:0] pick_reg();
		logic [31:0] r;
		r = next_random();
		return 5'(r % 32'd5);
	endfunction

	function automatic logic [31:0] sext12(input logic [11:0] v);
		return {{20{v[11]}}, v};
	endfunction

	function automatic logic [31:0] alu_ref(input logic [2:0] f3, input logic alt,
			input logic [31:0] a, input logic [31:0] b);
		case (f3)
			3'd0: return alt ? a - b : a + b;
			3'd1: return a << b[4:0];
			3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3: return (a < b) ? 32'd1 : 32'd0;
			3'd4: return a ^ b;
			3'd5: begin
				if (alt)
					return $unsigned($signed(a) >>> b[4:0]);
				return a >> b[4:0];
			end
			3'd6: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branch_ref(input logic [2:0] f3, input logic [31:0] a,
			input logic [31:0] b);
		case (f3)
			3'd0: return a == b;
			3'd1: return a != b;
			3'd4: return $signed(a) < $signed(b);
			3'd5: return $signed(a) >= $signed(b);
			3'd6: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic logic [31:0] unsupported_word(input logic [31:0] r);
		case (r[1:0])
			2'd0: return {r[31:7], 7'b0000011}; // load.
			2'd1: return {r[31:7], 7'b0100011}; // store.
			2'd2: return {7'b0000001, r[24:7], 7'b0110011}; // multiply and divide.
			default: return {r[31:7], 7'b1110011};
		endcase
	endfunction

	// builds one instruction of class cls and what it must produce.
	task automatic random_instr(input int cls, output logic [31:0] word,
			output logic has_res, output logic [4:0] rd, output logic [31:0] data,
			output logic has_redir, output logic [31:0] target);
		logic [31:0] r;
		logic [31:0] a;
		logic [31:0] b;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic        alt;
		logic [11:0] imm12;
		logic [12:0] off_b;
		logic [20:0] off_j;
		r = next_random();
		rd = pick_reg();
		rs1 = pick_reg();
		rs2 = pick_reg();
		a = arch_regs[rs1];
		b = arch_regs[rs2];
		f3 = r[2:0];
		alt = r[3] && (f3 == 3'd0 || f3 == 3'd5);
		imm12 = r[15:4];
		has_res = 1'b1;
		has_redir = 1'b0;
		data = '0;
		target = '0;
		case (cls)
			0: begin
				word = {alt ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'b0110011};
				data = alu_ref(f3, alt, a, b);
			end
			1: begin
				alt = alt && f3 == 3'd5;
				if (f3 == 3'd1 || f3 == 3'd5)
					imm12 = {1'b0, alt, 5'd0, r[20:16]}; // shift amount in the low bits.
				word = {imm12, rs1, f3, rd, 7'b0010011};
				data = alu_ref(f3, alt, a, sext12(imm12));
			end
			2: begin
				word = {r[31:12], rd, 7'b0110111};
				data = {r[31:12], 12'd0};
			end
			3: begin
				word = {r[31:12], rd, 7'b0010111};
				data = cur_pc + {r[31:12], 12'd0};
			end
			4: begin
				off_j = {r[31:12], 1'b0};
				word = {off_j[20], off_j[10:1], off_j[11], off_j[19:12], rd, 7'b1101111};
				data = cur_pc + 32'd4;
				has_redir = 1'b1;
				target = cur_pc + {{11{off_j[20]}}, off_j};
			end
			5: begin
				word = {imm12, rs1, 3'd0, rd, 7'b1100111};
				data = cur_pc + 32'd4;
				has_redir = 1'b1;
				target = (a + sext12(imm12)) & ~32'd1;
			end
			default: begin
				f3 = r[6:4];
				if (f3[2:1] == 2'b01)
					f3[2] = 1'b1; // 010 and 011 are not branch conditions.
				off_b = {r[27:16], 1'b0};
				word = {off_b[12], off_b[10:5], rs2, rs1, f3, off_b[4:1], off_b[11], 7'b1100011};
				has_res = 1'b0;
				has_redir = branch_ref(f3, a, b);
				target = cur_pc + {{19{off_b[12]}}, off_b};
			end
		endcase
		has_res = has_res && rd != 5'd0;
	endtask

	task automatic report_value(input string name, input logic [31:0] got,
			input logic [31:0] want);
		errors++;
		$display("[FAIL] cycle %0d %s: got %h, expected %h", cycle, name, got, want);
	endtask

	task automatic check_outputs();
		logic        e_res;
		logic [4:0]  e_rd;
		logic [31:0] e_data;
		logic        e_redir;
		logic [31:0] e_target;
		e_res = 1'b0;
		e_rd = '0;
		e_data = '0;
		e_redir = 1'b0;
		e_target = '0;
		if (exp_due.size() != 0 && exp_due[0] == cycle) begin
			void'(exp_due.pop_front());
			e_res = exp_res.pop_front();
			e_rd = exp_rd.pop_front();
			e_data = exp_data.pop_front();
			e_redir = exp_redir.pop_front();
			e_target = exp_target.pop_front();
		end
		checks++;
		if (result_valid !== e_res)
			report_value("result_valid", {31'd0, result_valid}, {31'd0, e_res});
		if (e_res && result_rd !== e_rd)
			report_value("result_rd", {27'd0, result_rd}, {27'd0, e_rd});
		if (e_res && result_data !== e_data)
			report_value("result_data", result_data, e_data);
		if (redirect_valid !== e_redir)
			report_value("redirect_valid", {31'd0, redirect_valid}, {31'd0, e_redir});
		if (e_redir && redirect_pc !== e_target)
			report_value("redirect_pc", redirect_pc, e_target);
	endtask

	// each call checks what is due in this cycle and then presents the next word.
	task automatic issue(input logic valid, input logic fl, input logic [31:0] word,
			input logic has_res, input logic [4:0] rd, input logic [31:0] data,
			input logic has_redir, input logic [31:0] target);
		@(negedge clk);
		cycle++;
		check_outputs();
		instr_valid = valid;
		instr = word;
		pc = cur_pc;
		flush = fl;
		if (valid && !fl && (has_res || has_redir)) begin
			exp_due.push_back(cycle + 2);
			exp_res.push_back(has_res);
			exp_rd.push_back(rd);
			exp_data.push_back(data);
			exp_redir.push_back(has_redir);
			exp_target.push_back(target);
		end
		if (valid && !fl && has_res)
			arch_regs[rd] = data;
		cur_pc = cur_pc + 32'd4;
	endtask

	task automatic run_test(input string name, input int mode, input int count);
		int          errs_before;
		int          cls;
		int          waited;
		logic [31:0] r;
		logic [31:0] word;
		logic [31:0] data;
		logic [31:0] target;
		logic [4:0]  rd;
		logic        has_res;
		logic        has_redir;
		logic        valid;
		logic        fl;
		errs_before = errors;
		for (int i = 0; i < count; i++) begin
			r = next_random();
			valid = (mode != 0);
			fl = (mode == 3) && r[9:8] == 2'd0;
			case (mode)
				2: cls = r[2] ? 6 : (r[3] ? 4 + int'(r[4]) : int'(r[5]));
				3: cls = int'(r[7:0] % 8'd7);
				default: cls = int'(r[1:0]);
			endcase
			random_instr(cls, word, has_res, rd, data, has_redir, target);
			if (mode == 4) begin
				case (r[11:10])
					2'd0: valid = 1'b0;
					2'd1: begin
						word = unsupported_word(next_random());
						has_res = 1'b0;
						has_redir = 1'b0;
					end
					2'd2: begin
						word[11:7] = 5'd0; // same operation aimed at x0.
						has_res = 1'b0;
					end
					default: ;
				endcase
			end
			issue(valid, fl, word, has_res, rd, data, has_redir, target);
		end
		// the last two words of a test still need their output cycles checked.
		waited = 0;
		while ((exp_due.size() != 0 || waited < 2) && waited < 8) begin
			issue(1'b0, 1'b0, '0, 1'b0, 5'd0, '0, 1'b0, '0);
			waited++;
		end
		if (exp_due.size() != 0) begin
			$display("test %s: expected outputs still missing after 8 idle cycles", name);
			errors++;
			timed_out = 1'b1;
		end
		if (errors == errs_before) begin
			tests_passed++;
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: failed with %0d errors", name, errors - errs_before);
		end
	endtask

	initial begin
		int waited;
		instr_valid = 1'b0;
		instr = '0;
		pc = '0;
		flush = 1'b0;
		lcg_state = 32'hb2b6;
		cur_pc = 32'h0000_1000;
		cycle = 0;
		errors = 0;
		checks = 0;
		tests_passed = 0;
		tests_failed = 0;
		timed_out = 1'b0;
		waited = 0;
		for (int i = 0; i < 32; i++)
			arch_regs[i] = '0;
		while (rst_n !== 1'b1 && waited < 20) begin
			@(negedge clk);
			waited++;
		end
		if (rst_n !== 1'b1) begin
			$display("reset was never released within 20 cycles");
			errors++;
			timed_out = 1'b1;
		end
		if (!timed_out)
			run_test("reset_idle", 0, 8);
		if (!timed_out)
			run_test("alu_random", 1, 300);
		if (!timed_out)
			run_test("control_flow", 2, 200);
		if (!timed_out)
			run_test("flush", 3, 200);
		if (!timed_out)
			run_test("no_effect", 4, 200);
		$display("%0d tests passed, %0d failed, %0d checks, %0d errors",
			tests_passed, tests_failed, checks, errors);
		if (errors == 0 && tests_failed == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule
